//--- video_pkg.sv
// Video path types and OSD colours
`default_nettype none

package video_pkg;

    // Bits per colour channel
    localparam int COLOR_W = 8;

    // One pixel with its sync, 27 bits
    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
        logic               hsync;
        logic               vsync;
        logic               de;
    } pixel_t;

    // Two pixels per FIFO word, first is the earlier one
    typedef struct packed {
        pixel_t first;
        pixel_t second;
    } pair_t;

    // OSD colour index
    typedef logic [1:0] osd_color_t;

    // OSD colour table, RGB
    localparam logic [3*COLOR_W-1:0] OSD_BLACK  = 24'h000000;
    localparam logic [3*COLOR_W-1:0] OSD_BLUE   = 24'h0000ff;
    localparam logic [3*COLOR_W-1:0] OSD_YELLOW = 24'hffff00;
    localparam logic [3*COLOR_W-1:0] OSD_WHITE  = 24'hffffff;

    // Output path status
    typedef struct packed {
        logic underflow;
    } status_t;

endpackage

`default_nettype wire

//--- capture_pair_packer.sv
// Capture source select and pixel pair packer
`timescale 1ns/1ns
`default_nettype none

module capture_pair_packer import video_pkg::*; (
    input  wire logic   pclk_out,
    input  wire logic   po_reset_n,
    input  wire logic   capture_sel_i,
    input  wire pixel_t isl_pix_i,
    input  wire logic   isl_valid_i,
    input  wire pixel_t hdmirx_pix_i,
    output pair_t       pair_o,
    output logic        pair_valid_o
);

    pixel_t cap_pix;
    logic   cap_valid;
    logic   second_slot;

    // Capture mux with one register stage
    always_ff @(posedge pclk_out) begin
        cap_pix <= capture_sel_i ? hdmirx_pix_i : isl_pix_i;
    end

    // HDMI receiver output counts as valid on every cycle
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cap_valid    <= 1'b0;
            second_slot  <= 1'b0;
            pair_valid_o <= 1'b0;
        end else begin
            cap_valid    <= capture_sel_i | isl_valid_i;
            pair_valid_o <= cap_valid & second_slot;
            if (cap_valid) begin
                second_slot <= ~second_slot;
            end
        end
    end

    // Holding register fills the first slot then the second
    always_ff @(posedge pclk_out) begin
        if (cap_valid) begin
            if (second_slot) begin
                pair_o.second <= cap_pix;
            end else begin
                pair_o.first <= cap_pix;
            end
        end
    end

endmodule

`default_nettype wire

//--- pair_fifo.sv
// Synchronous pixel pair FIFO
`timescale 1ns/1ns
`default_nettype none

module pair_fifo import video_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic  pclk_out,
    input  wire logic  po_reset_n,
    input  wire pair_t pair_i,
    input  wire logic  wr_i,
    input  wire logic  pop_i,
    output pair_t      pair_o,
    output logic       empty_o,
    output logic       full_o
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    pair_t             mem [FIFO_DEPTH];
    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic              wr_en;
    logic              rd_en;

    // Pair dropped when full
    assign wr_en = wr_i & ~full_o;
    assign rd_en = pop_i & ~empty_o;

    // Extra pointer bit tells full from empty
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // Show-ahead read
    assign pair_o = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge pclk_out) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= pair_i;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Consumer must only pop data that is there
    a_no_pop_empty : assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        pop_i |-> !empty_o
    ) else $error("pop while FIFO empty");

    // Rate match between packer and output stage keeps the FIFO from filling
    a_no_write_full : assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        wr_i |-> !full_o
    ) else $error("write while FIFO full, pair lost");

endmodule

`default_nettype wire

//--- pixel_output_stage.sv
// Pair unpack, OSD overlay and transmitter output registers
`timescale 1ns/1ns
`default_nettype none

module pixel_output_stage import video_pkg::*; (
    input  wire logic       pclk_out,
    input  wire logic       po_reset_n,
    input  wire pair_t      pair_i,
    input  wire logic       empty_i,
    input  wire logic       osd_enable_i,
    input  wire osd_color_t osd_color_i,
    output logic            pop_o,
    output pixel_t          hdmitx_o,
    output logic            frame_start_o,
    output status_t         status_o
);

    logic                 phase;
    pixel_t               unp_pix;
    pixel_t               hold_pix;
    pixel_t               osd_pix;
    logic                 unp_real;
    logic                 hold_real;
    logic                 vsync_prev;
    logic                 active;
    logic                 gap;
    logic [3*COLOR_W-1:0] osd_rgb;

    // One pair every second cycle
    assign pop_o = ~phase & ~empty_i;

    always_comb begin
        case (osd_color_i)
            2'd0:    osd_rgb = OSD_BLACK;
            2'd1:    osd_rgb = OSD_BLUE;
            2'd2:    osd_rgb = OSD_YELLOW;
            default: osd_rgb = OSD_WHITE;
        endcase
    end

    // Second pixel of the pair or a blank when nothing was popped
    always_ff @(posedge pclk_out) begin
        if (!phase) begin
            hold_pix <= pop_o ? pair_i.second : '0;
        end
    end

    // Unpack register takes the first pixel in phase 0 and the second in phase 1
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            phase     <= 1'b0;
            unp_pix   <= '0;
            unp_real  <= 1'b0;
            hold_real <= 1'b0;
        end else begin
            phase <= ~phase;
            if (!phase) begin
                unp_pix   <= pop_o ? pair_i.first : '0;
                unp_real  <= pop_o;
                hold_real <= pop_o;
            end else begin
                unp_pix  <= hold_pix;
                unp_real <= hold_real;
            end
        end
    end

    // Starved slot inside the stream is reported once data flows again
    // so the drain at the end of a stream is not an underflow
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            active   <= 1'b0;
            gap      <= 1'b0;
            status_o <= '0;
        end else if (!phase) begin
            if (pop_o) begin
                active <= 1'b1;
                gap    <= 1'b0;
                if (gap) begin
                    status_o.underflow <= 1'b1;
                end
            end else if (active) begin
                gap <= 1'b1;
            end
        end
    end

    // Frame start on falling vsync with hsync low among real pixels
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            vsync_prev    <= 1'b0;
            frame_start_o <= 1'b0;
        end else if (unp_real) begin
            vsync_prev    <= unp_pix.vsync;
            frame_start_o <= vsync_prev & ~unp_pix.vsync & ~unp_pix.hsync;
        end else begin
            frame_start_o <= 1'b0;
        end
    end

    // Stage 1 OSD colour override and stage 2 transmitter pins
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            osd_pix  <= '0;
            hdmitx_o <= '0;
        end else begin
            if (osd_enable_i) begin
                {osd_pix.r, osd_pix.g, osd_pix.b} <= osd_rgb;
            end else begin
                {osd_pix.r, osd_pix.g, osd_pix.b} <= {unp_pix.r, unp_pix.g, unp_pix.b};
            end
            osd_pix.hsync <= unp_pix.hsync;
            osd_pix.vsync <= unp_pix.vsync;
            osd_pix.de    <= unp_pix.de;
            hdmitx_o      <= osd_pix;
        end
    end

endmodule

`default_nettype wire

//--- video_out_top.sv
// External video output path
`timescale 1ns/1ns
`default_nettype none

module video_out_top import video_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic       pclk_out,
    input  wire logic       po_reset_n,
    input  wire logic       capture_sel_i,
    input  wire pixel_t     isl_pix_i,
    input  wire logic       isl_valid_i,
    input  wire pixel_t     hdmirx_pix_i,
    input  wire logic       osd_enable_i,
    input  wire osd_color_t osd_color_i,
    output pixel_t          hdmitx_o,
    output logic            frame_start_o,
    output status_t         status_o
);

    pair_t cap_pair;
    logic  cap_pair_valid;
    pair_t fifo_pair;
    logic  fifo_empty;
    logic  out_pop;

    capture_pair_packer u_packer (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .capture_sel_i(capture_sel_i),
        .isl_pix_i    (isl_pix_i),
        .isl_valid_i  (isl_valid_i),
        .hdmirx_pix_i (hdmirx_pix_i),
        .pair_o       (cap_pair),
        .pair_valid_o (cap_pair_valid)
    );

    // Full only matters to the FIFO write gate
    pair_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .pclk_out  (pclk_out),
        .po_reset_n(po_reset_n),
        .pair_i    (cap_pair),
        .wr_i      (cap_pair_valid),
        .pop_i     (out_pop),
        .pair_o    (fifo_pair),
        .empty_o   (fifo_empty),
        .full_o    ()
    );

    pixel_output_stage u_output (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .pair_i       (fifo_pair),
        .empty_i      (fifo_empty),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .pop_o        (out_pop),
        .hdmitx_o     (hdmitx_o),
        .frame_start_o(frame_start_o),
        .status_o     (status_o)
    );

endmodule

`default_nettype wire

//--- tb_video_checker.sv
// Expected pixel stream model and compare
`timescale 1ns/1ns
`default_nettype none

module tb_video_checker import video_pkg::*; (
    input  wire logic        pclk_out,
    input  wire logic        po_reset_n,
    input  wire logic        capture_sel_i,
    input  wire pixel_t      isl_pix_i,
    input  wire logic        isl_valid_i,
    input  wire pixel_t      hdmirx_pix_i,
    input  wire logic        osd_enable_i,
    input  wire osd_color_t  osd_color_i,
    input  wire pixel_t      hdmitx_i,
    input  wire logic        frame_start_i,
    input  wire status_t     status_i,
    input  wire logic        test_end_i,
    input  wire logic [15:0] test_num_i,
    input  wire logic        exp_underflow_i,
    output int               pending_o,
    output int               error_count_o,
    output int               failed_tests_o
);

    pixel_t      exp_q [$];
    logic        in_reset = 1'b1;
    logic        end_seen = 1'b0;
    logic [15:0] end_test_num;
    logic        end_underflow;
    logic        prev_vsync = 1'b0;
    int          exp_frames = 0;
    int          act_frames = 0;
    int          test_errors = 0;

    // Black, pure blue, yellow, white
    function automatic logic [23:0] osd_table(input logic [1:0] idx);
        case (idx)
            2'd0:    return 24'h000000;
            2'd1:    return 24'h0000ff;
            2'd2:    return 24'hffff00;
            default: return 24'hffffff;
        endcase
    endfunction

    task automatic report_test();
        if (exp_q.size() != 0) begin
            $display("Test %0d: %0d captured pixels never reached hdmitx_o",
                     end_test_num, exp_q.size());
            test_errors++;
        end
        if (act_frames != exp_frames) begin
            $display("Fail at %0t ns: frame_start_o pulses expected %0d got %0d",
                     $time, exp_frames, act_frames);
            test_errors++;
        end
        if (status_i.underflow !== end_underflow) begin
            $display("Fail at %0t ns: status_o.underflow expected %0d got %0d",
                     $time, end_underflow, status_i.underflow);
            test_errors++;
        end
        if (test_errors == 0) begin
            $display("Test %0d passed, %0d frame starts", end_test_num, act_frames);
        end else begin
            $display("Test %0d failed with %0d errors", end_test_num, test_errors);
            failed_tests_o++;
        end
        error_count_o += test_errors;
        test_errors = 0;
    endtask

    // Capture model follows the DUT input register at the rising edge
    always @(posedge pclk_out) begin : capture_model
        pixel_t pix;
        in_reset      = !po_reset_n;
        end_seen      = test_end_i;
        end_test_num  = test_num_i;
        end_underflow = exp_underflow_i;
        if (!po_reset_n) begin
            exp_q.delete();
            prev_vsync = 1'b0;
            exp_frames = 0;
        end else if (capture_sel_i || isl_valid_i) begin
            pix = capture_sel_i ? hdmirx_pix_i : isl_pix_i;
            if (prev_vsync && !pix.vsync && !pix.hsync) begin
                exp_frames++;
            end
            prev_vsync = pix.vsync;
            if (pix.de) begin
                if (osd_enable_i) begin
                    {pix.r, pix.g, pix.b} = osd_table(osd_color_i);
                end
                exp_q.push_back(pix);
            end
        end
        pending_o = exp_q.size();
    end

    // Outputs compared at the falling edge
    always @(negedge pclk_out) begin : output_compare
        pixel_t exp_pix;
        if (in_reset) begin
            act_frames = 0;
            if (hdmitx_i !== '0) begin
                $display("Fail at %0t ns: hdmitx_o in reset expected 0 got %h",
                         $time, hdmitx_i);
                test_errors++;
            end
            if (frame_start_i !== 1'b0) begin
                $display("Fail at %0t ns: frame_start_o in reset expected 0 got %b",
                         $time, frame_start_i);
                test_errors++;
            end
            if (status_i !== '0) begin
                $display("Fail at %0t ns: status_o in reset expected 0 got %b",
                         $time, status_i);
                test_errors++;
            end
        end else begin
            if (frame_start_i) begin
                act_frames++;
            end
            if (hdmitx_i.de) begin
                if (exp_q.size() == 0) begin
                    $display("Output pixel %h at %0t ns with no captured pixel left",
                             hdmitx_i, $time);
                    test_errors++;
                end else begin
                    exp_pix = exp_q.pop_front();
                    pending_o = exp_q.size();
                    if (hdmitx_i !== exp_pix) begin
                        $display("Fail at %0t ns: hdmitx_o expected %h got %h",
                                 $time, exp_pix, hdmitx_i);
                        test_errors++;
                    end
                end
            end
        end
        if (end_seen) begin
            report_test();
        end
    end

endmodule

`default_nettype wire

//--- tb_video_out.sv
// Video output path testbench
`timescale 1ns/1ns
`default_nettype none

module tb_video_out import video_pkg::*; ();

    localparam int MAX_TESTS    = 32;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 6;

    logic        pclk_out;
    logic        po_reset_n;
    logic        capture_sel;
    pixel_t      isl_pix;
    logic        isl_valid;
    pixel_t      hdmirx_pix;
    logic        osd_enable;
    osd_color_t  osd_color;
    pixel_t      hdmitx;
    logic        frame_start;
    status_t     status;
    logic        test_end;
    logic [15:0] test_num;
    logic        exp_underflow;
    int          pending;
    int          error_count;
    int          failed_tests;

    int          num_tests;
    int          t_num [MAX_TESTS];
    int          t_sel [MAX_TESTS];
    int          t_valid_mode [MAX_TESTS];
    int          t_osd_en [MAX_TESTS];
    int          t_osd_color [MAX_TESTS];
    int          t_pixels [MAX_TESTS];
    int          t_underflow [MAX_TESTS];
    int          cycle_limit = 0;
    int          cycle_count = 0;
    integer      seed;

    video_out_top #(
        .FIFO_DEPTH(16)
    ) dut_i (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .capture_sel_i(capture_sel),
        .isl_pix_i    (isl_pix),
        .isl_valid_i  (isl_valid),
        .hdmirx_pix_i (hdmirx_pix),
        .osd_enable_i (osd_enable),
        .osd_color_i  (osd_color),
        .hdmitx_o     (hdmitx),
        .frame_start_o(frame_start),
        .status_o     (status)
    );

    tb_video_checker u_checker (
        .pclk_out       (pclk_out),
        .po_reset_n     (po_reset_n),
        .capture_sel_i  (capture_sel),
        .isl_pix_i      (isl_pix),
        .isl_valid_i    (isl_valid),
        .hdmirx_pix_i   (hdmirx_pix),
        .osd_enable_i   (osd_enable),
        .osd_color_i    (osd_color),
        .hdmitx_i       (hdmitx),
        .frame_start_i  (frame_start),
        .status_i       (status),
        .test_end_i     (test_end),
        .test_num_i     (test_num),
        .exp_underflow_i(exp_underflow),
        .pending_o      (pending),
        .error_count_o  (error_count),
        .failed_tests_o (failed_tests)
    );

    initial begin
        pclk_out = 1'b0;
        forever begin
            #50 pclk_out = ~pclk_out;
        end
    end

    always @(posedge pclk_out) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d cycles before all tests finished", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic load_tests(output logic ok);
        int    fd;
        int    code;
        string line;
        int    tn, sel, vm, oe, oc, cnt, uf;
        ok = 1'b0;
        num_tests = 0;
        fd = $fopen("video_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) != 8'h23) begin
                    code = $sscanf(line, "%d %d %d %d %d %d %d", tn, sel, vm, oe, oc, cnt, uf);
                    if (code == 7) begin
                        t_num[num_tests]        = tn;
                        t_sel[num_tests]        = sel;
                        t_valid_mode[num_tests] = vm;
                        t_osd_en[num_tests]     = oe;
                        t_osd_color[num_tests]  = oc;
                        t_pixels[num_tests]     = cnt;
                        t_underflow[num_tests]  = uf;
                        cycle_limit += 4 * cnt + 200;
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
            ok = (num_tests > 0);
        end
    endtask

    task automatic drive_idle();
        capture_sel = 1'b0;
        isl_valid   = 1'b0;
        isl_pix     = '0;
        hdmirx_pix  = '0;
    endtask

    // Random colour and de with scripted syncs that have falling vsync edges
    task automatic make_pixel(input int k, input logic last, output pixel_t pix);
        logic [31:0] rnd;
        rnd       = $random(seed);
        pix.r     = rnd[7:0];
        pix.g     = rnd[15:8];
        pix.b     = rnd[23:16];
        pix.vsync = ((k / 5) % 2) == 0;
        pix.hsync = (k % 3) == 0;
        pix.de    = rnd[24] | rnd[25] | last;
    endtask

    task automatic run_test(input int idx);
        int     cycles;
        pixel_t p_isl;
        pixel_t p_hdmi;
        @(negedge pclk_out);
        po_reset_n    = 1'b0;
        osd_enable    = (t_osd_en[idx] != 0);
        osd_color     = osd_color_t'(t_osd_color[idx]);
        test_num      = t_num[idx][15:0];
        exp_underflow = (t_underflow[idx] != 0);
        repeat (RESET_CYCLES) @(negedge pclk_out);
        po_reset_n = 1'b1;
        cycles = (t_valid_mode[idx] != 0) ? 2 * t_pixels[idx] : t_pixels[idx];
        for (int k = 0; k < cycles; k++) begin
            @(negedge pclk_out);
            // Last pixel has de high so the drain wait covers the whole stream
            make_pixel(k, k == cycles - 1, p_isl);
            make_pixel(k, k == cycles - 1, p_hdmi);
            capture_sel = (t_sel[idx] != 0);
            if (t_sel[idx] != 0) begin
                // Digitizer valid toggles while every HDMI pixel must be taken
                isl_valid = (k % 2 == 0);
            end else begin
                isl_valid = (t_valid_mode[idx] == 0) || (k % 2 == 1);
            end
            isl_pix     = p_isl;
            hdmirx_pix  = p_hdmi;
        end
        @(negedge pclk_out);
        drive_idle();
        @(posedge pclk_out);
        while (pending != 0) begin
            @(posedge pclk_out);
        end
        repeat (IDLE_CYCLES) @(negedge pclk_out);
        test_end = 1'b1;
        @(negedge pclk_out);
        test_end = 1'b0;
        @(negedge pclk_out);
    endtask

    initial begin
        logic ok;
        seed          = 32'h4d87;
        po_reset_n    = 1'b0;
        osd_enable    = 1'b0;
        osd_color     = '0;
        test_end      = 1'b0;
        test_num      = '0;
        exp_underflow = 1'b0;
        drive_idle();
        load_tests(ok);
        if (!ok) begin
            $display("No test could be read from video_stim.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            for (int i = 0; i < num_tests; i++) begin
                run_test(i);
            end
            $display("Tests run %0d, failed %0d, errors %0d",
                     num_tests, failed_tests, error_count);
            if (error_count == 0 && failed_tests == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- video_stim.txt
# test capture_sel valid_mode(0 every cycle, 1 every other) osd_enable osd_color pixels underflow
# one test per line, decimal, pixel counts even
1 0 0 0 0 32 0
2 1 0 0 0 32 0
3 0 0 1 0 16 0
4 1 0 1 1 16 0
5 0 0 1 2 16 0
6 1 0 1 3 16 0
7 0 1 0 0 24 1
8 0 0 0 0 24 0
9 0 1 1 2 20 1
10 0 0 1 3 40 0

//--- flist.f
video_pkg.sv
capture_pair_packer.sv
pair_fifo.sv
pixel_output_stage.sv
video_out_top.sv
tb_video_checker.sv
tb_video_out.sv
